//--- rtl/psg_pkg.sv
// Shared definitions for the three-voice sound generator
// Register numbers follow the AY-3-8910 map and registers 14 and 15 are ignored
// Log volume values come from chip measurements and are indexed by a 5-bit level

`default_nettype none

package psg_pkg;

	// ********************
	// Register numbers
	// ********************
	localparam logic [3:0] PSG_REG_TONE_LO0  = 4'd0;
	localparam logic [3:0] PSG_REG_TONE_HI0  = 4'd1;
	localparam logic [3:0] PSG_REG_TONE_LO1  = 4'd2;
	localparam logic [3:0] PSG_REG_TONE_HI1  = 4'd3;
	localparam logic [3:0] PSG_REG_TONE_LO2  = 4'd4;
	localparam logic [3:0] PSG_REG_TONE_HI2  = 4'd5;
	localparam logic [3:0] PSG_REG_NOISE     = 4'd6;
	localparam logic [3:0] PSG_REG_MIXER     = 4'd7;
	localparam logic [3:0] PSG_REG_AMP0      = 4'd8;
	localparam logic [3:0] PSG_REG_AMP1      = 4'd9;
	localparam logic [3:0] PSG_REG_AMP2      = 4'd10;
	localparam logic [3:0] PSG_REG_ENV_LO    = 4'd11;
	localparam logic [3:0] PSG_REG_ENV_HI    = 4'd12;
	localparam logic [3:0] PSG_REG_ENV_SHAPE = 4'd13;

	// Widths
	localparam int PSG_TONE_W  = 12;
	localparam int PSG_ENV_W   = 16;
	localparam int PSG_AUDIO_W = 12;

	// A set mixer bit keeps that source's gate open
	typedef struct packed {
		logic [1:0] pad;
		logic [2:0] noise_off;
		logic [2:0] tone_off;
	} psg_mixer_t;

	// Amplitude byte
	typedef struct packed {
		logic [2:0] pad;
		logic       use_env;
		logic [3:0] level;
	} psg_amp_t;

	// One data byte, read either as mixer or as amplitude
	typedef union packed {
		psg_mixer_t mixer;
		psg_amp_t   amp;
	} psg_data_u;

	// ********************
	// Log volume table
	// ********************
	localparam logic [7:0] PSG_LOG_LUT [32] = '{
		8'd0,   8'd1,   8'd2,   8'd3,   8'd3,   8'd4,   8'd5,   8'd6,
		8'd8,   8'd9,   8'd11,  8'd13,  8'd16,  8'd18,  8'd24,  8'd29,
		8'd32,  8'd34,  8'd44,  8'd55,  8'd61,  8'd66,  8'd82,  8'd98,
		8'd114, 8'd130, 8'd148, 8'd166, 8'd187, 8'd207, 8'd231, 8'd255
	};

endpackage

`default_nettype wire

//--- rtl/psg_ctrl_if.sv
// Register state seen by the generators and the mixer
// Only the register file drives it, all other users read

`timescale 1ns/1ps
`default_nettype none

interface psg_ctrl_if;
	import psg_pkg::*;

	logic [2:0][PSG_TONE_W-1:0] tone_period;
	logic [4:0]                 noise_period;
	logic [PSG_ENV_W-1:0]       env_period;
	logic [3:0]                 env_shape;
	// One cycle, right after a shape write
	logic                       env_restart;
	psg_mixer_t                 mixer;
	psg_amp_t [2:0]             amp;

	modport regs (
		output tone_period, noise_period, env_period, env_shape, env_restart, mixer, amp
	);
	modport tone  (input tone_period);
	modport noise (input noise_period);
	modport env   (input env_period, env_shape, env_restart);
	modport mix   (input mixer, amp);

endinterface

`default_nettype wire

//--- rtl/psg_regs.sv
// Register file behind a two-step write bus
// Address write with bus_sel_i low, data write with bus_sel_i high
// Writes land on the next rising edge, there is no read-back

`timescale 1ns/1ps
`default_nettype none

module psg_regs (
	input  logic       audio_clk,
	input  logic       reset,
	input  logic       bus_wr_i,
	input  logic       bus_sel_i,
	input  logic [7:0] bus_d_i,
	psg_ctrl_if.regs   ctrl
);
	import psg_pkg::*;

	logic [3:0] reg_sel;
	logic       addr_wr;
	logic       data_wr;
	psg_data_u  wr_data;

	assign addr_wr = bus_wr_i & ~bus_sel_i;
	assign data_wr = bus_wr_i & bus_sel_i;
	assign wr_data = bus_d_i;

	// ********************
	// Select latch and write decode
	// ********************
	always_ff @(posedge audio_clk) begin
		if (reset) begin
			reg_sel           <= '0;
			ctrl.tone_period  <= '0;
			ctrl.noise_period <= '0;
			ctrl.env_period   <= '0;
			ctrl.env_shape    <= '0;
			ctrl.env_restart  <= 1'b0;
			ctrl.mixer        <= '0;
			ctrl.amp          <= '0;
		end else begin
			ctrl.env_restart <= 1'b0;
			if (addr_wr) begin
				reg_sel <= bus_d_i[3:0];
			end
			if (data_wr) begin
				case (reg_sel)
					// Tone pairs sit at 0/1, 2/3, 4/5
					PSG_REG_TONE_LO0, PSG_REG_TONE_LO1, PSG_REG_TONE_LO2: begin
						ctrl.tone_period[reg_sel[2:1]][7:0] <= bus_d_i;
					end
					PSG_REG_TONE_HI0, PSG_REG_TONE_HI1, PSG_REG_TONE_HI2: begin
						ctrl.tone_period[reg_sel[2:1]][PSG_TONE_W-1:8] <= bus_d_i[3:0];
					end
					PSG_REG_NOISE: begin
						ctrl.noise_period <= bus_d_i[4:0];
					end
					PSG_REG_MIXER: begin
						ctrl.mixer <= wr_data.mixer;
					end
					// Amplitudes at 8, 9, 10
					PSG_REG_AMP0, PSG_REG_AMP1, PSG_REG_AMP2: begin
						ctrl.amp[reg_sel[1:0]] <= wr_data.amp;
					end
					PSG_REG_ENV_LO: begin
						ctrl.env_period[7:0] <= bus_d_i;
					end
					PSG_REG_ENV_HI: begin
						ctrl.env_period[PSG_ENV_W-1:8] <= bus_d_i;
					end
					PSG_REG_ENV_SHAPE: begin
						ctrl.env_shape   <= bus_d_i[3:0];
						ctrl.env_restart <= 1'b1;
					end
					default: begin
						// Registers 14 and 15 have no effect
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/tone_gen.sv
// Square-wave tone channel, no prescaler
// Half-period is 16*P+1 audio_clk cycles, period 0 toggles every cycle

`timescale 1ns/1ps
`default_nettype none

module tone_gen #(
	parameter int unsigned CHAN = 0
) (
	input  logic     audio_clk,
	input  logic     reset,
	psg_ctrl_if.tone ctrl,
	output logic     wave_o
);
	import psg_pkg::*;

	logic [PSG_TONE_W+3:0] phase;

	// Phase divided by 16 is compared to the period
	always_ff @(posedge audio_clk) begin
		if (reset) begin
			phase  <= '0;
			wave_o <= 1'b0;
		end else if (phase[PSG_TONE_W+3:4] >= ctrl.tone_period[CHAN]) begin
			phase  <= '0;
			wave_o <= ~wave_o;
		end else begin
			phase <= phase + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- rtl/noise_gen.sv
// Noise source, 17-bit LFSR with taps 16 and 13
// Shifts once every 32*N+1 audio_clk cycles

`timescale 1ns/1ps
`default_nettype none

module noise_gen (
	input  logic      audio_clk,
	input  logic      reset,
	psg_ctrl_if.noise ctrl,
	output logic      wave_o
);
	logic [9:0]  phase;
	logic [16:0] lfsr;

	assign wave_o = lfsr[16];

	always_ff @(posedge audio_clk) begin
		if (reset) begin
			phase <= '0;
			// Non-zero seed, all zeros would lock up
			lfsr  <= 17'd1;
		end else if (phase[9:5] >= ctrl.noise_period) begin
			phase <= '0;
			lfsr  <= {lfsr[15:0], lfsr[16] ^ lfsr[13]};
		end else begin
			phase <= phase + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- rtl/envelope_gen.sv
// Envelope generator with the classic 4-bit shape
// 512 steps per ramp, level_o changes every 16 steps
// A shape write restarts the ramp from its first step

`timescale 1ns/1ps
`default_nettype none

module envelope_gen (
	input  logic       audio_clk,
	input  logic       reset,
	psg_ctrl_if.env    ctrl,
	output logic [4:0] level_o
);
	import psg_pkg::*;

	logic [PSG_ENV_W-1:0] phase;
	logic [8:0]           step_cnt;
	// Inverts the ramp direction
	logic                 env_cycle;
	logic                 env_held;

	logic shape_continue;
	logic shape_attack;
	logic shape_alternate;
	logic shape_hold;

	assign shape_continue  = ctrl.env_shape[3];
	assign shape_attack    = ctrl.env_shape[2];
	assign shape_alternate = ctrl.env_shape[1];
	assign shape_hold      = ctrl.env_shape[0];

	// Rising with attack set, falling otherwise
	assign level_o = step_cnt[8:4] ^ {5{~(shape_attack ^ env_cycle)}};

	// ********************
	// Period and step counters
	// ********************
	always_ff @(posedge audio_clk) begin
		if (reset || ctrl.env_restart) begin
			phase     <= '0;
			step_cnt  <= '0;
			env_cycle <= 1'b0;
			env_held  <= 1'b0;
		end else if (phase >= ctrl.env_period) begin
			phase <= '0;
			if (!env_held) begin
				if (step_cnt != '1) begin
					step_cnt <= step_cnt + 1'b1;
				end else if (!shape_continue) begin
					// Single ramp, park at 0
					env_held  <= 1'b1;
					env_cycle <= shape_attack;
				end else if (shape_hold) begin
					env_held  <= 1'b1;
					env_cycle <= env_cycle ^ shape_alternate;
				end else begin
					// Repeat, flipping direction when alternating
					step_cnt  <= '0;
					env_cycle <= env_cycle ^ shape_alternate;
				end
			end
		end else begin
			phase <= phase + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- rtl/psg_mixer.sv
// Voice gating, volume select and log lookup, then the final sum
// Two register stages, audio_o follows voice inputs two cycles later
// Output is five times the sum of the three log levels

`timescale 1ns/1ps
`default_nettype none

module psg_mixer (
	input  logic                            audio_clk,
	input  logic                            reset,
	psg_ctrl_if.mix                         ctrl,
	input  logic [2:0]                      tone_wave_i,
	input  logic                            noise_wave_i,
	input  logic [4:0]                      env_level_i,
	output logic [psg_pkg::PSG_AUDIO_W-1:0] audio_o
);
	import psg_pkg::*;

	logic [2:0]             gate;
	logic [2:0][4:0]        voice;
	logic [2:0][7:0]        level_q;
	logic [PSG_AUDIO_W-1:0] level_sum;

	// ********************
	// Gates and volume
	// ********************
	always_comb begin
		for (int ch = 0; ch < 3; ch++) begin
			gate[ch] = (tone_wave_i[ch] | ctrl.mixer.tone_off[ch])
				& (noise_wave_i | ctrl.mixer.noise_off[ch]);
			if (!gate[ch]) begin
				voice[ch] = 5'd0;
			end else if (ctrl.amp[ch].use_env) begin
				voice[ch] = env_level_i;
			end else begin
				// Fixed level uses the even table entries
				voice[ch] = {ctrl.amp[ch].level, 1'b0};
			end
		end
	end

	assign level_sum = PSG_AUDIO_W'(level_q[0])
		+ PSG_AUDIO_W'(level_q[1])
		+ PSG_AUDIO_W'(level_q[2]);

	// ********************
	// Level and sum registers
	// ********************
	always_ff @(posedge audio_clk) begin
		if (reset) begin
			level_q <= '0;
			audio_o <= '0;
		end else begin
			for (int ch = 0; ch < 3; ch++) begin
				level_q[ch] <= PSG_LOG_LUT[voice[ch]];
			end
			// Times five, max 3825 fits in 12 bits
			audio_o <= (level_sum << 2) + level_sum;
		end
	end

endmodule

`default_nettype wire

//--- rtl/sunsoft_psg.sv
// Three-voice sound generator, single clock domain
// Register bus is write-only with no back-pressure, one write per cycle at most
// audio_o is unsigned and sampled every cycle

`timescale 1ns/1ps
`default_nettype none

module sunsoft_psg (
	input  logic                            audio_clk,
	input  logic                            reset,
	input  logic                            bus_wr_i,
	input  logic                            bus_sel_i,
	input  logic [7:0]                      bus_d_i,
	output logic [psg_pkg::PSG_AUDIO_W-1:0] audio_o
);
	psg_ctrl_if ctrl_bus ();

	logic [2:0] tone_wave;
	logic       noise_wave;
	logic [4:0] env_level;

	psg_regs regs_i (
		.audio_clk (audio_clk),
		.reset     (reset),
		.bus_wr_i  (bus_wr_i),
		.bus_sel_i (bus_sel_i),
		.bus_d_i   (bus_d_i),
		.ctrl      (ctrl_bus.regs)
	);

	// One tone channel per voice
	for (genvar ch = 0; ch < 3; ch++) begin : g_tone
		tone_gen #(
			.CHAN (ch)
		) tone_i (
			.audio_clk (audio_clk),
			.reset     (reset),
			.ctrl      (ctrl_bus.tone),
			.wave_o    (tone_wave[ch])
		);
	end

	noise_gen noise_i (
		.audio_clk (audio_clk),
		.reset     (reset),
		.ctrl      (ctrl_bus.noise),
		.wave_o    (noise_wave)
	);

	envelope_gen env_i (
		.audio_clk (audio_clk),
		.reset     (reset),
		.ctrl      (ctrl_bus.env),
		.level_o   (env_level)
	);

	psg_mixer mixer_i (
		.audio_clk    (audio_clk),
		.reset        (reset),
		.ctrl         (ctrl_bus.mix),
		.tone_wave_i  (tone_wave),
		.noise_wave_i (noise_wave),
		.env_level_i  (env_level),
		.audio_o      (audio_o)
	);

endmodule

`default_nettype wire

//--- tests/psg_tb.sv
// Testbench for the three-voice sound generator
// Drives the two-step register bus and checks audio_o against a reference model
// Tone periods stay within 1 to 8 and the envelope period is fixed at 1

`timescale 1ns/1ps
`default_nettype none

module psg_tb;
	import psg_pkg::*;

	localparam int CLK_PERIOD      = 4;
	localparam int RESET_CYCLES    = 8;
	localparam int WRITE_CYCLES    = 3;
	localparam int IDLE_CYCLES     = 10;
	localparam int FIXED_RUNS      = 20;
	localparam int FIXED_CYCLES    = FIXED_RUNS * (4 * WRITE_CYCLES + 4);
	localparam int TONE_RUNS       = 3;
	localparam int TONE_SKIP       = 2;
	localparam int TONE_CHANGES    = 4;
	localparam int TONE_P_MAX      = 8;
	localparam int TONE_CYCLES     = TONE_RUNS * (6 * WRITE_CYCLES
		+ (TONE_SKIP + TONE_CHANGES + 1) * (16 * TONE_P_MAX + 1));
	localparam int NOISE_N         = 1;
	localparam int NOISE_WINDOW    = 2000;
	localparam int NOISE_CYCLES    = 5 * WRITE_CYCLES + NOISE_WINDOW;
	localparam int ENV_E           = 1;
	localparam int ENV_TAIL        = 256;
	localparam int ENV_WINDOW      = 512 * (ENV_E + 1) + ENV_TAIL;
	localparam int ENV_CYCLES      = 7 * WRITE_CYCLES + 4 + ENV_WINDOW;
	localparam int MARGIN_CYCLES   = 200;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + IDLE_CYCLES + FIXED_CYCLES
		+ TONE_CYCLES + NOISE_CYCLES + 2 * ENV_CYCLES + MARGIN_CYCLES;

	logic                   audio_clk;
	logic                   reset;
	logic                   bus_wr_i;
	logic                   bus_sel_i;
	logic [7:0]             bus_d_i;
	logic [PSG_AUDIO_W-1:0] audio_o;

	logic [31:0] rnd_state = 32'h9ab8;

	// Request to the comparison process
	string cmp_name;
	int    cmp_exp;
	int    cmp_act;
	bit    cmp_pending = 1'b0;

	sunsoft_psg sunsoft_psg_i (
		.audio_clk (audio_clk),
		.reset     (reset),
		.bus_wr_i  (bus_wr_i),
		.bus_sel_i (bus_sel_i),
		.bus_d_i   (bus_d_i),
		.audio_o   (audio_o)
	);

	initial begin
		audio_clk = 1'b0;
		forever #(CLK_PERIOD / 2) audio_clk = ~audio_clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Gate each voice, pick env or doubled fixed level, look up the table and scale by five
	function automatic int expected_audio(
		input logic [2:0]      gate_open,
		input logic [2:0]      use_env,
		input logic [2:0][3:0] level,
		input logic [4:0]      env_level
	);
		int         sum;
		logic [4:0] idx;
		sum = 0;
		for (int ch = 0; ch < 3; ch++) begin
			if (!gate_open[ch]) begin
				idx = 5'd0;
			end else if (use_env[ch]) begin
				idx = env_level;
			end else begin
				idx = level[ch] * 5'd2;
			end
			sum += PSG_LOG_LUT[idx];
		end
		return 5 * sum;
	endfunction

	task automatic report_failure(input string line);
		$display("%s", line);
		$display("test failed");
	endtask

	task automatic check_value(input string name, input int exp_val, input int act_val);
		cmp_name    = name;
		cmp_exp     = exp_val;
		cmp_act     = act_val;
		cmp_pending = 1'b1;
		wait (!cmp_pending);
	endtask

	// Address cycle followed by a data cycle
	task automatic write_reg(input logic [3:0] addr, input logic [7:0] data);
		@(posedge audio_clk);
		bus_wr_i  <= 1'b1;
		bus_sel_i <= 1'b0;
		bus_d_i   <= {4'd0, addr};
		@(posedge audio_clk);
		bus_sel_i <= 1'b1;
		bus_d_i   <= data;
		@(posedge audio_clk);
		bus_wr_i  <= 1'b0;
		bus_sel_i <= 1'b0;
	endtask

	// ********************
	// Comparison process
	// ********************
	always begin
		wait (cmp_pending);
		assert (cmp_act == cmp_exp) else begin
			report_failure($sformatf("Fail %s: expected %0d, actual %0d",
				cmp_name, cmp_exp, cmp_act));
			$fatal(1);
		end
		cmp_pending = 1'b0;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		report_failure("Watchdog expired before all tests finished");
		$fatal(1);
	end

	// ********************
	// Tests
	// ********************
	task automatic idle_after_reset();
		for (int i = 0; i < IDLE_CYCLES; i++) begin
			@(negedge audio_clk);
			check_value("reset", 0, int'(audio_o));
		end
	endtask

	task automatic fixed_volume_levels();
		logic [2:0][3:0] levels;
		for (int run = 0; run < FIXED_RUNS; run++) begin
			write_reg(PSG_REG_MIXER, 8'h3f);
			for (int ch = 0; ch < 3; ch++) begin
				rnd_state  = xorshift(rnd_state);
				levels[ch] = rnd_state[3:0];
				// Random pad bits with use_env clear
				write_reg(PSG_REG_AMP0 + 4'(ch), {rnd_state[7:5], 1'b0, levels[ch]});
			end
			repeat (3) @(posedge audio_clk);
			@(negedge audio_clk);
			check_value("fixed_volume", expected_audio(3'b111, 3'b000, levels, 5'd0),
				int'(audio_o));
		end
	endtask

	task automatic tone_half_period();
		int                     p;
		int                     cnt;
		int                     changes;
		int                     hi_val;
		logic [PSG_AUDIO_W-1:0] last;
		hi_val = expected_audio(3'b001, 3'b000, {4'd0, 4'd0, 4'd15}, 5'd0);
		for (int run = 0; run < TONE_RUNS; run++) begin
			rnd_state = xorshift(rnd_state);
			p = int'(rnd_state[2:0]) + 1;
			write_reg(PSG_REG_AMP1, 8'h00);
			write_reg(PSG_REG_AMP2, 8'h00);
			write_reg(PSG_REG_MIXER, 8'h3e);
			write_reg(PSG_REG_AMP0, 8'h0f);
			write_reg(PSG_REG_TONE_LO0, 8'(p));
			write_reg(PSG_REG_TONE_HI0, 8'h00);
			@(negedge audio_clk);
			last    = audio_o;
			cnt     = 0;
			changes = 0;
			// First changes may still follow the old period
			while (changes < TONE_SKIP + TONE_CHANGES) begin
				@(negedge audio_clk);
				cnt++;
				if (audio_o != 0) begin
					check_value("tone_period level", hi_val, int'(audio_o));
				end
				if (audio_o != last) begin
					changes++;
					if (changes > TONE_SKIP) begin
						check_value("tone_period", 16 * p + 1, cnt);
					end
					last = audio_o;
					cnt  = 0;
				end
			end
		end
	endtask

	task automatic noise_levels();
		int hi_val;
		bit seen_low;
		bit seen_high;
		hi_val    = expected_audio(3'b001, 3'b000, {4'd0, 4'd0, 4'd15}, 5'd0);
		seen_low  = 1'b0;
		seen_high = 1'b0;
		// Mixer first so the tone has left the output before the window
		write_reg(PSG_REG_MIXER, 8'h37);
		write_reg(PSG_REG_AMP1, 8'h00);
		write_reg(PSG_REG_AMP2, 8'h00);
		write_reg(PSG_REG_AMP0, 8'h0f);
		write_reg(PSG_REG_NOISE, 8'(NOISE_N));
		for (int i = 0; i < NOISE_WINDOW; i++) begin
			@(negedge audio_clk);
			if (audio_o == 0) begin
				seen_low = 1'b1;
			end else begin
				check_value("noise level", hi_val, int'(audio_o));
				seen_high = 1'b1;
			end
		end
		assert (seen_low && seen_high) else begin
			report_failure("Noise output did not take both levels within the window");
			$fatal(1);
		end
	endtask

	task automatic envelope_ramp(input logic [3:0] shape, input string name);
		int         exp_q[$];
		int         obs_q[$];
		int         v;
		logic [4:0] lvl;
		for (int k = 0; k < 32; k++) begin
			lvl = shape[2] ? 5'(k) : 5'(31 - k);
			v   = expected_audio(3'b111, 3'b001, '0, lvl);
			// Equal neighbours in the table give no visible step
			if (exp_q.size() == 0 || v != exp_q[$]) begin
				exp_q.push_back(v);
			end
		end
		write_reg(PSG_REG_MIXER, 8'h3f);
		write_reg(PSG_REG_AMP1, 8'h00);
		write_reg(PSG_REG_AMP2, 8'h00);
		write_reg(PSG_REG_AMP0, 8'h10);
		write_reg(PSG_REG_ENV_LO, 8'(ENV_E));
		write_reg(PSG_REG_ENV_HI, 8'h00);
		write_reg(PSG_REG_ENV_SHAPE, {4'd0, shape});
		// Restart plus mixer latency before the ramp reaches audio_o
		repeat (3) @(posedge audio_clk);
		@(negedge audio_clk);
		obs_q.push_back(int'(audio_o));
		for (int i = 0; i < ENV_WINDOW; i++) begin
			@(negedge audio_clk);
			if (int'(audio_o) != obs_q[$]) begin
				obs_q.push_back(int'(audio_o));
			end
		end
		check_value({name, " steps"}, exp_q.size(), obs_q.size());
		for (int i = 0; i < exp_q.size(); i++) begin
			check_value(name, exp_q[i], obs_q[i]);
		end
	endtask

	initial begin
		reset     = 1'b1;
		bus_wr_i  = 1'b0;
		bus_sel_i = 1'b0;
		bus_d_i   = 8'h00;
		repeat (RESET_CYCLES) @(posedge audio_clk);
		reset <= 1'b0;

		idle_after_reset();
		fixed_volume_levels();
		tone_half_period();
		noise_levels();
		envelope_ramp(4'd13, "envelope_up");
		envelope_ramp(4'd0, "envelope_down");

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
rtl/psg_pkg.sv
rtl/psg_ctrl_if.sv
rtl/psg_regs.sv
rtl/tone_gen.sv
rtl/noise_gen.sv
rtl/envelope_gen.sv
rtl/psg_mixer.sv
rtl/sunsoft_psg.sv
tests/psg_tb.sv

//--- Bender.yml
package:
  name: sunsoft_psg

sources:
  - rtl/psg_pkg.sv
  - rtl/psg_ctrl_if.sv
  - rtl/psg_regs.sv
  - rtl/tone_gen.sv
  - rtl/noise_gen.sv
  - rtl/envelope_gen.sv
  - rtl/psg_mixer.sv
  - rtl/sunsoft_psg.sv
  - target: test
    files:
      - tests/psg_tb.sv
